// File: coreAgentTestdata.txt
# R reset | C op target hasResp respData | P pc valid count (pc 0 gives random fillers)
# T valid entry0..entry4 | E wait tile core monitor pass fail (wait 1 polls with a timeout)
# Reset state and release-tile target filter
E 0 1 0 0 0 0
C 2 2 0 0
E 0 1 0 0 0 0
C 2 1 0 0
E 0 0 0 0 0 0
# Core reset, monitor enable and reset-status query
C 3 1 0 0
E 0 0 1 0 0 0
C 6 0 1 1
C 4 1 0 0
E 0 0 0 0 0 0
C 6 3 1 0
C 5 1 0 0
E 0 0 0 1 0 0
# Pass on entry 2, pass/fail query, then sleep
T 1 80001000 80001100 80001200 80001300 80001400
P 0 1 3
E 0 0 0 1 0 0
P 80001200 1 1
E 0 0 0 1 1 0
C 7 0 1 1
E 1 0 1 1 1 0
# Stuck PC, then the same run with the stuck checker off
R
P 80002000 1 8
E 0 1 0 0 0 1
E 1 1 1 0 0 1
R
C 8 0 0 0
P 80002000 1 8
E 0 1 0 0 0 0
# Table not loaded, single-core pass, fail entry 4
R
T 0 80001000 80001100 80001200 80001300 80001400
P 80001200 1 1
E 1 1 0 0 0 1
C 7 0 1 2
R
T 1 80001000 80001100 80001200 80001300 80001400
C 9 0 0 0
P 0 1 1
E 0 1 0 0 1 0
R
P 80001400 1 1
E 0 1 0 0 0 1

// File: project.f
coreCtrlPkg.sv
pcWatchPkg.sv
flagDecode.sv
resetExecute.sv
pcResult.sv
coreAgent.sv
coreAgentTb.sv

// File: Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --assert -Wno-fatal --top-module coreAgentTb -f project.f
	./obj_dir/VcoreAgentTb | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: coreAgentTb.sv
// Testbench for coreAgent, driven by coreAgentTestdata.txt read from the project root
// Expected values in the data file assume MyCoreId 1, StuckLimit 8 and SleepDelay 4
`timescale 1ns/1ps

module coreAgentTb;

  localparam int ResetCycles = 16;
  localparam int WaitLimit   = 60;  // Cycles before a wait gives up

  logic                 dvtFlags;
  logic                 pcFail;
  coreCtrlPkg::cmdReqT  cmd;
  pcWatchPkg::pcSampleT pcSample;
  pcWatchPkg::pcTableT  passFailTable;
  logic                 tableValid;
  coreCtrlPkg::respT    resp;
  logic                 tileReset;
  logic                 coreReset;
  logic                 monitorEnable;
  logic                 testPass;
  logic                 testFail;

  integer seed;
  integer fd;

  coreAgent #(
    .MyCoreId   (1),
    .StuckLimit (8),
    .SleepDelay (4)
  ) coreAgent_i (
    .dvtFlags      (dvtFlags),
    .pcFail        (pcFail),
    .cmd           (cmd),
    .pcSample      (pcSample),
    .passFailTable (passFailTable),
    .tableValid    (tableValid),
    .resp          (resp),
    .tileReset     (tileReset),
    .coreReset     (coreReset),
    .monitorEnable (monitorEnable),
    .testPass      (testPass),
    .testFail      (testFail)
  );

  initial begin
    dvtFlags = 1'b0;
    forever #20 dvtFlags = ~dvtFlags;  // 40 ns period
  end

  // ------------------------------
  // Checks
  // ------------------------------
  task automatic stopRun(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic checkLevel(input string name, input logic expVal, input logic actVal);
    if (actVal !== expVal) begin
      stopRun($sformatf("** Error at %t: %s expected %b, got %b",
                        $time, name, expVal, actVal));
    end
  endtask

  task automatic checkResp(input coreCtrlPkg::respDataT expData,
                           input coreCtrlPkg::respDataT actData);
    if (actData !== expData) begin
      stopRun($sformatf("** Error at %t: resp.data expected %b, got %b",
                        $time, expData, actData));
    end
  endtask

  task automatic checkVerdict(input logic expPass, input logic expFail,
                              input logic actPass, input logic actFail);
    if (actPass !== expPass) begin
      stopRun($sformatf("** Error at %t: testPass expected %b, got %b",
                        $time, expPass, actPass));
    end
    if (actFail !== expFail) begin
      stopRun($sformatf("** Error at %t: testFail expected %b, got %b",
                        $time, expFail, actFail));
    end
  endtask

  // ------------------------------
  // Data file parsing
  // ------------------------------
  function automatic int nextKind();
    int ch;
    ch = $fgetc(fd);
    while (ch == 32 || ch == 9 || ch == 10 || ch == 13) begin
      ch = $fgetc(fd);
    end
    return ch;  // -1 at end of file
  endfunction

  task automatic skipLine();
    int ch;
    ch = $fgetc(fd);
    while (ch != 10 && ch != -1) begin
      ch = $fgetc(fd);
    end
  endtask

  // Top nibble F keeps filler PCs clear of the table, whose addresses start with 8
  function automatic pcWatchPkg::pcT fillerPc();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = $random(seed);
    lo = $random(seed);
    return {4'hF, hi[27:0], lo};
  endfunction

  task automatic pulseReset();
    @(posedge dvtFlags);
    pcFail <= 1'b1;
    repeat (ResetCycles) @(posedge dvtFlags);
    pcFail <= 1'b0;
  endtask

  // Command in cycle N, response sampled mid cycle N+2
  task automatic sendCommand();
    logic [3:0]            opV;
    coreCtrlPkg::coreIdT   tgtV;
    logic                  hasResp;
    coreCtrlPkg::respDataT expData;
    coreCtrlPkg::cmdReqT   req;
    int                    got;
    got = $fscanf(fd, "%h %h %h %h", opV, tgtV, hasResp, expData);
    if (got != 4) begin
      stopRun("A command record in the data file is incomplete");
    end
    req.valid  = 1'b1;
    req.op     = coreCtrlPkg::cmdOpT'(opV);
    req.target = tgtV;
    @(posedge dvtFlags);
    cmd <= req;
    @(posedge dvtFlags);
    cmd <= '0;
    @(posedge dvtFlags);
    @(negedge dvtFlags);
    checkLevel("resp.valid", hasResp, resp.valid);
    if (hasResp) begin
      checkResp(expData, resp.data);
    end
  endtask

  task automatic driveSamples();
    pcWatchPkg::pcT       pcV;
    logic                 validV;
    int                   count;
    int                   got;
    pcWatchPkg::pcSampleT smp;
    got = $fscanf(fd, "%h %h %d", pcV, validV, count);
    if (got != 3) begin
      stopRun("A PC record in the data file is incomplete");
    end
    for (int i = 0; i < count; i++) begin
      smp.valid = validV;
      smp.pc    = (pcV == '0) ? fillerPc() : pcV;  // Zero asks for a filler
      @(posedge dvtFlags);
      pcSample <= smp;
    end
    @(posedge dvtFlags);
    pcSample <= '0;
  endtask

  task automatic loadTable();
    logic                validV;
    pcWatchPkg::pcT      ent [5];
    pcWatchPkg::pcTableT tbl;
    int                  got;
    got = $fscanf(fd, "%h %h %h %h %h %h", validV, ent[0], ent[1], ent[2], ent[3], ent[4]);
    if (got != 6) begin
      stopRun("A table record in the data file is incomplete");
    end
    for (int i = 0; i < 5; i++) begin
      tbl.entry[i] = ent[i];
    end
    @(posedge dvtFlags);
    tableValid    <= validV;
    passFailTable <= tbl;
  endtask

  task automatic compareOutputs();
    logic       waitMode;
    logic       expTile;
    logic       expCore;
    logic       expMon;
    logic       expPass;
    logic       expFail;
    logic [4:0] expVec;
    int         cycles;
    int         got;
    got = $fscanf(fd, "%h %h %h %h %h %h", waitMode, expTile, expCore, expMon, expPass, expFail);
    if (got != 6) begin
      stopRun("An expect record in the data file is incomplete");
    end
    expVec = {expTile, expCore, expMon, expPass, expFail};
    cycles = 0;
    @(negedge dvtFlags);
    // Sleep and verdicts settle within a few cycles
    while (waitMode &&
           ({tileReset, coreReset, monitorEnable, testPass, testFail} !== expVec)) begin
      if (cycles >= WaitLimit) begin
        stopRun($sformatf("Timed out: reset, monitor or verdict outputs %s %0d cycles",
                          "did not reach the expected levels within", WaitLimit));
      end else begin
        @(negedge dvtFlags);
        cycles++;
      end
    end
    checkLevel("tileReset", expTile, tileReset);
    checkLevel("coreReset", expCore, coreReset);
    checkLevel("monitorEnable", expMon, monitorEnable);
    checkVerdict(expPass, expFail, testPass, testFail);
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    int kind;
    $timeformat(-9, 0, " ns", 0);
    seed          = 32'h94a9068f;
    pcFail        = 1'b1;
    cmd           = '0;
    pcSample      = '0;
    passFailTable = '0;
    tableValid    = 1'b0;
    fd = $fopen("coreAgentTestdata.txt", "r");
    if (fd == 0) begin
      stopRun("Could not open coreAgentTestdata.txt for reading");
    end
    repeat (ResetCycles) @(posedge dvtFlags);
    pcFail <= 1'b0;
    kind = nextKind();
    while (kind != -1) begin
      case (8'(kind))
        "#":     skipLine();
        "R":     pulseReset();
        "C":     sendCommand();
        "P":     driveSamples();
        "T":     loadTable();
        "E":     compareOutputs();
        default: stopRun($sformatf("Unknown record kind '%c' in the data file", kind));
      endcase
      kind = nextKind();
    end
    $fclose(fd);
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

// File: coreAgent.sv
// Per-core control agent: command decode, reset control and PC checking
// Parameters are set here and passed down to the three blocks
`timescale 1ns/1ps

module coreAgent #(
  parameter int MyCoreId   = 0,
  parameter int StuckLimit = 500,  // Must fit in 16 bits
  parameter int SleepDelay = 20
) (
  input  logic                 dvtFlags,
  input  logic                 pcFail,
  input  coreCtrlPkg::cmdReqT  cmd,
  input  pcWatchPkg::pcSampleT pcSample,
  input  pcWatchPkg::pcTableT  passFailTable,
  input  logic                 tableValid,
  output coreCtrlPkg::respT    resp,
  output logic                 tileReset,
  output logic                 coreReset,
  output logic                 monitorEnable,
  output logic                 testPass,
  output logic                 testFail
);

  coreCtrlPkg::execCtlT execCtl;  // One cycle after the command

  flagDecode #(
    .MyCoreId (MyCoreId)
  ) flagDecode_i (
    .dvtFlags (dvtFlags),
    .pcFail   (pcFail),
    .cmd      (cmd),
    .execCtl  (execCtl)
  );

  resetExecute #(
    .SleepDelay (SleepDelay)
  ) resetExecute_i (
    .dvtFlags      (dvtFlags),
    .pcFail        (pcFail),
    .execCtl       (execCtl),
    .testPass      (testPass),
    .testFail      (testFail),
    .tileReset     (tileReset),
    .coreReset     (coreReset),
    .monitorEnable (monitorEnable)
  );

  pcResult #(
    .MyCoreId   (MyCoreId),
    .StuckLimit (StuckLimit)
  ) pcResult_i (
    .dvtFlags      (dvtFlags),
    .pcFail        (pcFail),
    .execCtl       (execCtl),
    .pcSample      (pcSample),
    .passFailTable (passFailTable),
    .tableValid    (tableValid),
    .coreReset     (coreReset),
    .testPass      (testPass),
    .testFail      (testFail),
    .resp          (resp)
  );

endmodule

// File: pcResult.sv
// Pass/fail detection on retired PCs, stuck checker and status responses
// StuckLimit must be at least 2 and fit in 16 bits; samples are ignored in core reset
`timescale 1ns/1ps

module pcResult #(
  parameter int MyCoreId   = 0,
  parameter int StuckLimit = 500
) (
  input  logic                  dvtFlags,
  input  logic                  pcFail,
  input  coreCtrlPkg::execCtlT  execCtl,
  input  pcWatchPkg::pcSampleT  pcSample,
  input  pcWatchPkg::pcTableT   passFailTable,
  input  logic                  tableValid,
  input  logic                  coreReset,
  output logic                  testPass,
  output logic                  testFail,
  output coreCtrlPkg::respT     resp
);

  pcWatchPkg::pcT       lastPc;
  pcWatchPkg::stuckCntT stuckCnt;
  pcWatchPkg::stuckCntT stuckNext;
  logic                 stuckDisable;
  logic                 singleCore;
  logic                 sampleOk;
  logic                 repeatPc;
  logic                 stuckTrip;
  logic                 hitPass;
  logic                 hitFail;
  logic                 passSet;
  logic                 ruleFail;
  logic                 query;

  assign sampleOk = pcSample.valid && !coreReset;
  // An empty count means no earlier PC to compare against
  assign repeatPc = (stuckCnt != '0) && (pcSample.pc == lastPc);

  assign hitPass = (pcSample.pc == passFailTable.entry[0]) ||
                   (pcSample.pc == passFailTable.entry[2]) ||
                   (pcSample.pc == passFailTable.entry[3]);
  assign hitFail = (pcSample.pc == passFailTable.entry[1]) ||
                   (pcSample.pc == passFailTable.entry[4]);

  // ------------------------------
  // Stuck checker
  // ------------------------------
  always_comb begin
    if (!repeatPc) begin
      stuckNext = pcWatchPkg::stuckCntT'(1);  // New PC starts a fresh run
    end else if (stuckCnt == pcWatchPkg::stuckCntT'(StuckLimit)) begin
      stuckNext = stuckCnt;  // Saturate
    end else begin
      stuckNext = stuckCnt + 1'b1;
    end
  end

  assign stuckTrip = sampleOk && !stuckDisable &&
                     (stuckNext == pcWatchPkg::stuckCntT'(StuckLimit));

  always_ff @(posedge dvtFlags or posedge pcFail) begin
    if (pcFail) begin
      stuckCnt <= '0;
    end else if (sampleOk) begin
      stuckCnt <= stuckNext;
    end
  end

  always_ff @(posedge dvtFlags) begin
    if (sampleOk) begin
      lastPc <= pcSample.pc;
    end
  end

  // ------------------------------
  // Table rules, first match wins
  // ------------------------------
  always_comb begin
    passSet  = 1'b0;
    ruleFail = 1'b0;
    if (sampleOk) begin
      if (!tableValid) begin
        ruleFail = 1'b1;  // Table never loaded
      end else if (hitPass) begin
        passSet = 1'b1;
      end else if (hitFail) begin
        ruleFail = 1'b1;
      end else if (singleCore && (MyCoreId != 0)) begin
        passSet = 1'b1;  // Other cores pass straight away
      end
    end
  end

  // Checker config and sticky verdicts
  always_ff @(posedge dvtFlags or posedge pcFail) begin
    if (pcFail) begin
      stuckDisable <= 1'b0;
      singleCore   <= 1'b0;
      testPass     <= 1'b0;
      testFail     <= 1'b0;
    end else begin
      if (execCtl.disableStuck || execCtl.singleCore) begin
        stuckDisable <= 1'b1;
      end
      if (execCtl.singleCore) begin
        singleCore <= 1'b1;
      end
      testPass <= testPass | passSet;
      testFail <= testFail | ruleFail | stuckTrip;
    end
  end

  // ------------------------------
  // Status responses
  // ------------------------------
  assign query = execCtl.getResetStatus | execCtl.getPassFail;

  always_ff @(posedge dvtFlags or posedge pcFail) begin
    if (pcFail) begin
      resp <= '0;
    end else begin
      resp.valid <= query;
      if (execCtl.getPassFail) begin
        resp.data <= coreCtrlPkg::respDataT'({testFail, testPass});
      end else if (execCtl.getResetStatus) begin
        resp.data <= coreCtrlPkg::respDataT'({1'b0, coreReset});
      end else begin
        resp.data <= '0;
      end
    end
  end

  // Both queries in one cycle would lose the reset-status reply
  assert property (@(posedge dvtFlags) disable iff (pcFail)
    !(execCtl.getResetStatus && execCtl.getPassFail))
    else $error("reset-status and pass/fail queries arrived in the same cycle");

endmodule

// File: resetExecute.sv
// Holds tile and core reset levels and puts the core to sleep after a verdict
// SleepDelay must be at least 2; the sleep fires once per run
`timescale 1ns/1ps

module resetExecute #(
  parameter int SleepDelay = 20
) (
  input  logic                 dvtFlags,
  input  logic                 pcFail,
  input  coreCtrlPkg::execCtlT execCtl,
  input  logic                 testPass,
  input  logic                 testFail,
  output logic                 tileReset,
  output logic                 coreReset,
  output logic                 monitorEnable
);

  localparam int CntW = $clog2(SleepDelay + 1);

  typedef enum logic [1:0] {
    sleepIdle,
    sleepCount,
    sleepDone
  } sleepStateT;

  sleepStateT      sleepState;
  logic [CntW-1:0] sleepCnt;
  logic            verdict;
  logic            verdictQ;
  logic            verdictRise;
  logic            sleepFire;

  assign verdict     = testPass | testFail;
  assign verdictRise = verdict & ~verdictQ;
  assign sleepFire   = (sleepState == sleepCount) && (sleepCnt == CntW'(SleepDelay - 1));

  // ------------------------------
  // Reset and monitor levels
  // ------------------------------
  always_ff @(posedge dvtFlags or posedge pcFail) begin
    if (pcFail) begin
      tileReset     <= 1'b1;  // Tile stays in reset until released
      coreReset     <= 1'b0;
      monitorEnable <= 1'b0;
    end else begin
      if (execCtl.forceTile) begin
        tileReset <= 1'b1;
      end else if (execCtl.releaseTile) begin
        tileReset <= 1'b0;
      end

      // Sleep wins over a release in the same cycle
      if (execCtl.forceCore || sleepFire) begin
        coreReset <= 1'b1;
      end else if (execCtl.releaseCore) begin
        coreReset <= 1'b0;
      end

      if (execCtl.enableMonitor) begin
        monitorEnable <= 1'b1;
      end
    end
  end

  // ------------------------------
  // Sleep FSM
  // ------------------------------
  always_ff @(posedge dvtFlags or posedge pcFail) begin
    if (pcFail) begin
      sleepState <= sleepIdle;
      sleepCnt   <= '0;
      verdictQ   <= 1'b0;
    end else begin
      verdictQ <= verdict;
      case (sleepState)
        sleepIdle: begin
          // Only a running core is put to sleep
          if (verdictRise && !coreReset) begin
            sleepState <= sleepCount;
            sleepCnt   <= CntW'(1);  // First edge after the verdict
          end
        end
        sleepCount: begin
          sleepCnt <= sleepCnt + 1'b1;
          if (sleepFire) begin
            sleepState <= sleepDone;
          end
        end
        sleepDone: sleepState <= sleepDone;  // A later release does not rearm
        default:   sleepState <= sleepIdle;
      endcase
    end
  end

  // Delay counter stays inside its range across the whole sleep sequence
  assert property (@(posedge dvtFlags) disable iff (pcFail)
    sleepCnt <= CntW'(SleepDelay))
    else $error("sleep counter passed SleepDelay: %0d", sleepCnt);

endmodule

// File: flagDecode.sv
// Registers each command strobe into one control bit, valid one cycle later
// Tile, core and monitor operations only act when the target is this core
`timescale 1ns/1ps

module flagDecode #(
  parameter int MyCoreId = 0
) (
  input  logic                 dvtFlags,
  input  logic                 pcFail,
  input  coreCtrlPkg::cmdReqT  cmd,
  output coreCtrlPkg::execCtlT execCtl
);

  logic                 forMe;
  coreCtrlPkg::execCtlT ctlNext;

  assign forMe = (cmd.target == coreCtrlPkg::coreIdT'(MyCoreId));

  // ------------------------------
  // Opcode decode
  // ------------------------------
  always_comb begin
    ctlNext = '0;
    if (cmd.valid) begin
      case (cmd.op)
        coreCtrlPkg::cmdForceTile:      ctlNext.forceTile     = forMe;
        coreCtrlPkg::cmdReleaseTile:    ctlNext.releaseTile   = forMe;
        coreCtrlPkg::cmdForceCore:      ctlNext.forceCore     = forMe;
        coreCtrlPkg::cmdReleaseCore:    ctlNext.releaseCore   = forMe;
        coreCtrlPkg::cmdEnableMonitor:  ctlNext.enableMonitor = forMe;
        // Queries and checker settings ignore the target
        coreCtrlPkg::cmdGetResetStatus: ctlNext.getResetStatus = 1'b1;
        coreCtrlPkg::cmdGetPassFail:    ctlNext.getPassFail    = 1'b1;
        coreCtrlPkg::cmdDisableStuck:   ctlNext.disableStuck   = 1'b1;
        coreCtrlPkg::cmdSingleCore:     ctlNext.singleCore     = 1'b1;
        default:                        ctlNext = '0;  // Nop
      endcase
    end
  end

  always_ff @(posedge dvtFlags or posedge pcFail) begin
    if (pcFail) begin
      execCtl <= '0;
    end else begin
      execCtl <= ctlNext;
    end
  end

  // Downstream blocks never see two operations in the same cycle
  assert property (@(posedge dvtFlags) disable iff (pcFail) $onehot0(execCtl))
    else $error("execCtl carries more than one operation: %b", execCtl);

endmodule

// File: pcWatchPkg.sv
// Program counter watch types; the table holds five addresses
// Entries 0, 2 and 3 mean pass, entries 1 and 4 mean fail

package pcWatchPkg;

  typedef logic [63:0] pcT;

  // Retired PC from the core, valid for one cycle
  typedef struct packed {
    logic valid;
    pcT   pc;
  } pcSampleT;

  // entry[0] sits in the low 64 bits
  typedef struct packed {
    pcT [4:0] entry;
  } pcTableT;

  typedef logic [15:0] stuckCntT;  // Run length of an unchanged PC

endpackage

// File: coreCtrlPkg.sv
// Command, decoded control and status response types for one core agent
// Commands are single-cycle strobes; there is no handshake

package coreCtrlPkg;

  typedef logic [1:0] coreIdT;    // Target core number

  // ------------------------------
  // Command opcodes
  // ------------------------------
  typedef enum logic [3:0] {
    cmdNop            = 4'd0,
    cmdForceTile      = 4'd1,
    cmdReleaseTile    = 4'd2,
    cmdForceCore      = 4'd3,
    cmdReleaseCore    = 4'd4,
    cmdEnableMonitor  = 4'd5,
    cmdGetResetStatus = 4'd6,
    cmdGetPassFail    = 4'd7,
    cmdDisableStuck   = 4'd8,
    cmdSingleCore     = 4'd9
  } cmdOpT;

  typedef struct packed {
    logic   valid;
    cmdOpT  op;
    coreIdT target;
  } cmdReqT;

  // One bit per operation, high for a single cycle
  typedef struct packed {
    logic forceTile;
    logic releaseTile;
    logic forceCore;
    logic releaseCore;
    logic enableMonitor;
    logic getResetStatus;
    logic getPassFail;
    logic disableStuck;
    logic singleCore;
  } execCtlT;

  typedef logic [1:0] respDataT;  // {fail, pass} or {0, coreReset}

  typedef struct packed {
    logic     valid;
    respDataT data;
  } respT;

endpackage
